// File: source/node_pkg.sv
package node_pkg;

	// memory geometry, 4k by 8
	localparam int ADDR_W = 12;
	localparam int DATA_W = 8;

	// serial bit time in clocks, kept small for simulation
	localparam int CLKS_PER_BIT = 16;
	localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);

	// serial frame: opcode and addr high, addr low, data
	localparam int FRAME_BYTES = 3;
	localparam logic [3:0] FRAME_OP_WRITE = 4'h1;

	// button synchronizer depth
	localparam int SYNC_STAGES = 2;

	// bus opcode, one bit on the wire
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_t;

	typedef enum logic [1:0] {ARB_IDLE, ARB_BUSY, ARB_DONE} arb_state_t;

	typedef enum logic [1:0] {P_IDLE, P_REQ, P_RELEASE} panel_state_t;

	typedef enum logic [1:0] {F_COLLECT, F_REQ, F_RELEASE} frame_state_t;

	typedef enum logic [1:0] {U_IDLE, U_START, U_DATA, U_STOP} uart_state_t;

endpackage

// File: source/node_arbiter.sv
`timescale 1ns/10ps

module node_arbiter import node_pkg::*; (
	input  logic              clock,
	input  logic              rst,
	input  logic              p_req,
	input  bus_op_t           p_op,
	input  logic [ADDR_W-1:0] p_addr,
	input  logic [DATA_W-1:0] p_wdata,
	output logic              p_ack,
	output logic [DATA_W-1:0] p_rdata,
	input  logic              s_req,
	input  bus_op_t           s_op,
	input  logic [ADDR_W-1:0] s_addr,
	input  logic [DATA_W-1:0] s_wdata,
	output logic              s_ack,
	output logic [DATA_W-1:0] s_rdata,
	output logic              mem_req,
	output bus_op_t           mem_op,
	output logic [ADDR_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata,
	input  logic              mem_ack,
	input  logic [DATA_W-1:0] mem_rdata
);

	arb_state_t        state;
	// 1 when the serial side holds or last held the grant
	logic              last_served;
	logic              pick_serial;
	logic              granted_req;
	logic              ack_q;
	logic [DATA_W-1:0] rdata_q;

	// serial wins if alone, or if both ask and panel went last
	assign pick_serial = s_req && (!p_req || !last_served);
	assign granted_req = last_served ? s_req : p_req;

	// ack only reaches the granted master
	assign p_ack   = ack_q & ~last_served;
	assign s_ack   = ack_q & last_served;
	assign p_rdata = rdata_q;
	assign s_rdata = rdata_q;

	always_ff @(posedge clock) begin
		if (rst) begin
			state       <= ARB_IDLE;
			last_served <= 1'b1;
			mem_req     <= 1'b0;
			ack_q       <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (p_req || s_req) begin
						last_served <= pick_serial;
						mem_req     <= 1'b1;
						state       <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					// pass memory ack up, then wait for the master to let go
					if (!ack_q && mem_ack) begin
						ack_q <= 1'b1;
					end else if (ack_q && !granted_req) begin
						ack_q   <= 1'b0;
						mem_req <= 1'b0;
						state   <= ARB_DONE;
					end
				end
				ARB_DONE: begin
					// memory must finish its release before a new grant
					if (!mem_ack) begin
						state <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// request payload follows the winner while idle, frozen once busy
	always_ff @(posedge clock) begin
		if (state == ARB_IDLE) begin
			mem_op    <= pick_serial ? s_op : p_op;
			mem_addr  <= pick_serial ? s_addr : p_addr;
			mem_wdata <= pick_serial ? s_wdata : p_wdata;
		end
		if (state == ARB_BUSY && !ack_q && mem_ack) begin
			rdata_q <= mem_rdata;
		end
	end

	// a released master must see its ack drop within a cycle
	a_p_ack_drop: assert property (@(posedge clock) disable iff (rst)
		!p_req && $past(!p_req) |-> !p_ack);
	a_s_ack_drop: assert property (@(posedge clock) disable iff (rst)
		!s_req && $past(!s_req) |-> !s_ack);
	// no new memory request until the old ack is gone
	a_mem_four_phase: assert property (@(posedge clock) disable iff (rst)
		$rose(mem_req) |-> !mem_ack);

endmodule

// File: source/bram_slave.sv
`timescale 1ns/10ps

module bram_slave import node_pkg::*; (
	input  logic              clock,
	input  logic              rst,
	input  logic              mem_req,
	input  bus_op_t           mem_op,
	input  logic [ADDR_W-1:0] mem_addr,
	input  logic [DATA_W-1:0] mem_wdata,
	output logic              mem_ack,
	output logic [DATA_W-1:0] mem_rdata
);

	logic [DATA_W-1:0] mem [0:(2**ADDR_W)-1];
	logic              access;

	// new request seen, ack not yet raised
	assign access = mem_req && !mem_ack;

	// handshake side
	always_ff @(posedge clock) begin
		if (rst) begin
			mem_ack <= 1'b0;
		end else if (access) begin
			mem_ack <= 1'b1;
		end else if (!mem_req && mem_ack) begin
			mem_ack <= 1'b0;
		end
	end

	// array side, read before write on the same address
	always_ff @(posedge clock) begin
		if (access) begin
			mem_rdata <= mem[mem_addr];
			if (mem_op == OP_WRITE) begin
				mem[mem_addr] <= mem_wdata;
			end
		end
	end

	// arbiter must keep the address steady into the access cycle
	a_addr_stable: assert property (@(posedge clock) disable iff (rst)
		mem_req && !mem_ack |=> $stable(mem_addr));

endmodule

// File: source/panel_master.sv
`timescale 1ns/10ps

module panel_master import node_pkg::*; (
	input  logic              clock,
	input  logic              rst,
	input  logic              enable,
	input  logic              button_raw,
	input  logic [DATA_W-1:0] switch_array,
	input  logic              mode_switch,
	output logic              req,
	output bus_op_t           op,
	output logic [ADDR_W-1:0] addr,
	output logic [DATA_W-1:0] wdata,
	input  logic              ack,
	input  logic [DATA_W-1:0] rdata,
	output logic [DATA_W-1:0] shown_data
);

	panel_state_t           state;
	logic [SYNC_STAGES-1:0] btn_sync;
	logic                   btn_prev;
	logic                   press;

	// rising edge of the synced button, gated by enable
	assign press = btn_sync[SYNC_STAGES-1] && !btn_prev && enable;

	always_ff @(posedge clock) begin
		if (rst) begin
			btn_sync   <= '0;
			btn_prev   <= 1'b0;
			state      <= P_IDLE;
			req        <= 1'b0;
			addr       <= '0;
			shown_data <= '0;
		end else begin
			btn_sync <= {btn_sync[SYNC_STAGES-2:0], button_raw};
			btn_prev <= btn_sync[SYNC_STAGES-1];
			case (state)
				P_IDLE: begin
					// presses while busy are simply dropped
					if (press) begin
						if (!mode_switch) begin
							// switches pick the address, upper bits zero
							addr <= {{(ADDR_W-DATA_W){1'b0}}, switch_array};
						end
						req   <= 1'b1;
						state <= P_REQ;
					end
				end
				P_REQ: begin
					if (ack) begin
						req        <= 1'b0;
						shown_data <= (op == OP_WRITE) ? wdata : rdata;
						state      <= P_RELEASE;
					end
				end
				P_RELEASE: begin
					if (!ack) begin
						state <= P_IDLE;
					end
				end
				default: state <= P_IDLE;
			endcase
		end
	end

	// opcode and write byte captured with the press
	always_ff @(posedge clock) begin
		if (state == P_IDLE && press) begin
			op    <= mode_switch ? OP_WRITE : OP_READ;
			wdata <= switch_array;
		end
	end

endmodule

// File: source/uart_rx.sv
`timescale 1ns/10ps

module uart_rx import node_pkg::*; (
	input  logic              clock,
	input  logic              rst,
	input  logic              rx,
	output logic              byte_valid,
	output logic [DATA_W-1:0] byte_data,
	output logic              frame_error
);

	uart_state_t           state;
	logic                  rx_meta;
	logic                  rx_sync;
	logic [BAUD_CNT_W-1:0] clk_cnt;
	logic [2:0]            bit_idx;
	logic [DATA_W-1:0]     shift_q;
	logic                  half_bit;
	logic                  full_bit;

	assign half_bit  = (clk_cnt == BAUD_CNT_W'(CLKS_PER_BIT/2 - 1));
	assign full_bit  = (clk_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));
	// shift register is complete when the valid pulse fires
	assign byte_data = shift_q;

	always_ff @(posedge clock) begin
		if (rst) begin
			// line idles high
			rx_meta     <= 1'b1;
			rx_sync     <= 1'b1;
			state       <= U_IDLE;
			clk_cnt     <= '0;
			bit_idx     <= '0;
			byte_valid  <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			rx_meta     <= rx;
			rx_sync     <= rx_meta;
			byte_valid  <= 1'b0;
			frame_error <= 1'b0;
			clk_cnt     <= clk_cnt + 1'b1;
			case (state)
				U_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync) state <= U_START;
				end
				U_START: begin
					// recheck start bit at its middle, glitches go back
					if (half_bit) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? U_IDLE : U_DATA;
					end
				end
				U_DATA: begin
					if (full_bit) begin
						clk_cnt <= '0;
						// lsb first
						shift_q <= {rx_sync, shift_q[DATA_W-1:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) state <= U_STOP;
					end
				end
				U_STOP: begin
					if (full_bit) begin
						byte_valid  <= rx_sync;
						frame_error <= !rx_sync;
						state       <= U_IDLE;
					end
				end
				default: state <= U_IDLE;
			endcase
		end
	end

endmodule

// File: source/frame_master.sv
`timescale 1ns/10ps

module frame_master import node_pkg::*; (
	input  logic              clock,
	input  logic              rst,
	input  logic              byte_valid,
	input  logic [DATA_W-1:0] byte_data,
	input  logic              frame_error,
	output logic              req,
	output bus_op_t           op,
	output logic [ADDR_W-1:0] addr,
	output logic [DATA_W-1:0] wdata,
	input  logic              ack
);

	frame_state_t state;
	logic [1:0]   byte_cnt;
	logic [3:0]   op_nibble;
	logic         last_byte;

	// only writes come in over serial
	assign op        = OP_WRITE;
	assign last_byte = (byte_cnt == 2'(FRAME_BYTES - 1));

	always_ff @(posedge clock) begin
		if (rst) begin
			state    <= F_COLLECT;
			byte_cnt <= '0;
			req      <= 1'b0;
		end else begin
			case (state)
				F_COLLECT: begin
					if (frame_error) begin
						// partial frame thrown away
						byte_cnt <= '0;
					end else if (byte_valid) begin
						byte_cnt <= last_byte ? 2'd0 : byte_cnt + 1'b1;
						// opcode judged once the whole frame is in
						if (last_byte && op_nibble == FRAME_OP_WRITE) begin
							req   <= 1'b1;
							state <= F_REQ;
						end
					end
				end
				F_REQ: begin
					if (ack) begin
						req   <= 1'b0;
						state <= F_RELEASE;
					end
				end
				F_RELEASE: begin
					if (!ack) state <= F_COLLECT;
				end
				default: state <= F_COLLECT;
			endcase
		end
	end

	// frame fields land by byte position
	always_ff @(posedge clock) begin
		if (state == F_COLLECT && byte_valid && !frame_error) begin
			case (byte_cnt)
				2'd0: begin
					op_nibble           <= byte_data[7:4];
					addr[ADDR_W-1:DATA_W] <= byte_data[ADDR_W-DATA_W-1:0];
				end
				2'd1: addr[DATA_W-1:0] <= byte_data;
				default: wdata <= byte_data;
			endcase
		end
	end

endmodule

// File: source/seg7_decode.sv
`timescale 1ns/10ps

module seg7_decode (
	input  logic [3:0] nibble,
	input  logic       blank,
	output logic [6:0] seg
);

	// active low, bit 0 is segment a, bit 6 is g
	always_comb begin
		case (nibble)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'ha: seg = 7'b0001000;
			4'hb: seg = 7'b0000011;
			4'hc: seg = 7'b1000110;
			4'hd: seg = 7'b0100001;
			4'he: seg = 7'b0000110;
			default: seg = 7'b0001110;
		endcase
		// blank overrides any glyph
		if (blank) seg = 7'b1111111;
	end

endmodule

// File: source/node_top.sv
`timescale 1ns/10ps

module node_top import node_pkg::*; (
	input  logic              clock,
	input  logic              rst,
	input  logic              enable,
	input  logic              button_raw,
	input  logic [DATA_W-1:0] switch_array,
	input  logic              mode_switch,
	input  logic              uart_rx,
	output logic [6:0]        display_hi,
	output logic [6:0]        display_lo
);

	// panel link
	logic              p_req, p_ack;
	bus_op_t           p_op;
	logic [ADDR_W-1:0] p_addr;
	logic [DATA_W-1:0] p_wdata, p_rdata;
	// serial link
	logic              s_req, s_ack;
	bus_op_t           s_op;
	logic [ADDR_W-1:0] s_addr;
	logic [DATA_W-1:0] s_wdata;
	// memory link
	logic              mem_req, mem_ack;
	bus_op_t           mem_op;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata, mem_rdata;
	// receiver to framer
	logic              byte_valid, frame_error;
	logic [DATA_W-1:0] byte_data;
	logic [DATA_W-1:0] shown_data;
	logic              blank;

	// digits go dark with the node disabled
	assign blank = ~enable;

	panel_master panel0 (.clock, .rst, .enable, .button_raw, .switch_array, .mode_switch,
		.req(p_req), .op(p_op), .addr(p_addr), .wdata(p_wdata), .ack(p_ack),
		.rdata(p_rdata), .shown_data);

	uart_rx rx0 (.clock, .rst, .rx(uart_rx), .byte_valid, .byte_data, .frame_error);

	frame_master frame0 (.clock, .rst, .byte_valid, .byte_data, .frame_error,
		.req(s_req), .op(s_op), .addr(s_addr), .wdata(s_wdata), .ack(s_ack));

	// serial side has no read path, its rdata stays open
	node_arbiter arb0 (.clock, .rst, .p_req, .p_op, .p_addr, .p_wdata, .p_ack, .p_rdata,
		.s_req, .s_op, .s_addr, .s_wdata, .s_ack, .s_rdata(),
		.mem_req, .mem_op, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata);

	bram_slave bram0 (.clock, .rst, .mem_req, .mem_op, .mem_addr, .mem_wdata,
		.mem_ack, .mem_rdata);

	seg7_decode seg_hi (.nibble(shown_data[7:4]), .blank, .seg(display_hi));
	seg7_decode seg_lo (.nibble(shown_data[3:0]), .blank, .seg(display_lo));

endmodule

// File: dv/node_tb.sv
`timescale 1ns/10ps

module node_tb import node_pkg::*; ;

	// one frame is 3 bytes of 10 bits plus a 2 bit gap
	localparam int FRAME_CYCLES = (FRAME_BYTES * 10 + 2) * CLKS_PER_BIT;
	// setup cycle plus 4 cycles high plus the 40 cycle display settle
	localparam int PRESS_CYCLES = 45;
	localparam int RANDOM_ROUNDS = 30;
	// directed part sends 6 frames and makes 10 presses
	localparam int MAX_FRAMES = 6 + RANDOM_ROUNDS;
	// each random round adds one frame or up to two presses
	localparam int MAX_PRESSES = 10 + 2 * RANDOM_ROUNDS;
	localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CYCLES + MAX_PRESSES * PRESS_CYCLES
		+ 1000;
	// button edge lines up with byte_valid of the third byte
	localparam int CONTEND_DELAY = 2 * 10 * CLKS_PER_BIT + 9 * CLKS_PER_BIT + CLKS_PER_BIT / 2;

	logic              clock = 1'b0;
	logic              rst;
	logic              enable;
	logic              button_raw;
	logic [DATA_W-1:0] switch_array;
	logic              mode_switch;
	logic              serial_line;
	logic [6:0]        display_hi;
	logic [6:0]        display_lo;

	// reference memory and which bytes hold a known value
	logic [DATA_W-1:0] model [0:(2**ADDR_W)-1];
	bit                known [0:(2**ADDR_W)-1];
	logic [ADDR_W-1:0] latched_addr;
	logic [31:0]       lfsr_q = 32'hbfe1;
	logic [13:0]       exp_seg;
	event              press_evt;

	node_top dut0 (.clock, .rst, .enable, .button_raw, .switch_array, .mode_switch,
		.uart_rx(serial_line), .display_hi, .display_lo);

	always #4 clock = ~clock;

	// galois step for taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// standard hex glyph as lit segments gfedcba, returned active low
	function automatic logic [6:0] glyph(input logic [3:0] n);
		logic [6:0] lit;
		case (n)
			4'h0: lit = 7'h3f;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5b;
			4'h3: lit = 7'h4f;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6d;
			4'h6: lit = 7'h7d;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7f;
			4'h9: lit = 7'h6f;
			4'ha: lit = 7'h77;
			4'hb: lit = 7'h7c;
			4'hc: lit = 7'h39;
			4'hd: lit = 7'h5e;
			4'he: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	// expected {display_hi, display_lo} for a shown byte
	function automatic logic [13:0] seg_pair(input logic [7:0] b);
		return {glyph(b[7:4]), glyph(b[3:0])};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	// 8N1 byte sent lsb first with the caller's stop level
	task automatic send_byte(input logic [7:0] data, input logic stop_bit);
		serial_line <= 1'b0;
		repeat (CLKS_PER_BIT) @(posedge clock);
		for (int i = 0; i < 8; i++) begin
			serial_line <= data[i];
			repeat (CLKS_PER_BIT) @(posedge clock);
		end
		serial_line <= stop_bit;
		repeat (CLKS_PER_BIT) @(posedge clock);
	endtask

	// bad stop bit goes on the last byte
	task automatic send_frame(input logic [11:0] a, input logic [7:0] d, input logic [3:0] opc,
			input logic stop_ok);
		send_byte({opc, a[11:8]}, 1'b1);
		send_byte(a[7:0], 1'b1);
		send_byte(d, stop_ok);
		// line idles high through the gap
		serial_line <= 1'b1;
		repeat (2 * CLKS_PER_BIT) @(posedge clock);
		// only a clean write frame reaches memory
		if (opc == FRAME_OP_WRITE && stop_ok) begin
			model[a] = d;
			known[a] = 1'b1;
		end
	endtask

	// mode low latches the switches as address and reads
	// mode high writes the switches to the latched address
	task automatic press_button(input logic mode, input logic [7:0] sw);
		logic do_check;
		switch_array <= sw;
		mode_switch  <= mode;
		@(posedge clock);
		button_raw <= 1'b1;
		if (mode) begin
			model[latched_addr] = sw;
			known[latched_addr] = 1'b1;
		end else begin
			latched_addr = {4'h0, sw};
		end
		// bytes never written read back undefined and go unchecked
		do_check = known[latched_addr];
		if (do_check) begin
			exp_seg = seg_pair(model[latched_addr]);
			-> press_evt;
		end
		repeat (4) @(posedge clock);
		button_raw <= 1'b0;
		repeat (40) @(posedge clock);
	endtask

	// display sampled 40 cycles after the button edge
	initial begin
		forever begin
			@(press_evt);
			repeat (40) @(posedge clock);
			check_value("display_hi", display_hi, exp_seg[13:7]);
			check_value("display_lo", display_lo, exp_seg[6:0]);
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("ERRORS FOUND");
		$fatal(1);
	end

	initial begin
		logic [1:0] kind;
		logic [7:0] a_lo;
		logic [3:0] a_hi;
		logic [7:0] d;
		rst          <= 1'b1;
		enable       <= 1'b1;
		button_raw   <= 1'b0;
		switch_array <= '0;
		mode_switch  <= 1'b0;
		serial_line  <= 1'b1;
		latched_addr = '0;
		repeat (5) @(posedge clock);
		rst <= 1'b0;
		repeat (2) @(posedge clock);
		// display register cleared by reset
		check_value("display_hi", display_hi, glyph(4'h0));
		check_value("display_lo", display_lo, glyph(4'h0));
		enable <= 1'b0;
		repeat (2) @(posedge clock);
		check_value("display_hi", display_hi, 7'h7f);
		check_value("display_lo", display_lo, 7'h7f);
		enable <= 1'b1;
		@(posedge clock);
		// address 0 still latched from reset
		press_button(1'b1, 8'ha5);
		press_button(1'b0, 8'h00);
		// serial write below 256 and then one above 255 on the same low byte
		send_frame(12'h012, 8'h3c, FRAME_OP_WRITE, 1'b1);
		press_button(1'b0, 8'h12);
		send_frame(12'h512, 8'hc3, FRAME_OP_WRITE, 1'b1);
		press_button(1'b0, 8'h12);
		// broken stop bit and wrong opcode frames followed by a good frame
		send_frame(12'h012, 8'h77, FRAME_OP_WRITE, 1'b0);
		press_button(1'b0, 8'h12);
		send_frame(12'h012, 8'h88, 4'h2, 1'b1);
		press_button(1'b0, 8'h12);
		send_frame(12'h012, 8'h5e, FRAME_OP_WRITE, 1'b1);
		press_button(1'b0, 8'h12);
		// both masters ask in the same cycle
		// panel write goes to the latched 0x012
		fork
			send_frame(12'h034, 8'hd2, FRAME_OP_WRITE, 1'b1);
			begin
				repeat (CONTEND_DELAY) @(posedge clock);
				press_button(1'b1, 8'h6b);
			end
		join
		press_button(1'b0, 8'h12);
		press_button(1'b0, 8'h34);
		// random mix over a 16 byte window
		for (int i = 0; i < RANDOM_ROUNDS; i++) begin
			kind = 2'(take_bits(2));
			a_lo = {4'h3, 4'(take_bits(4))};
			d    = 8'(take_bits(8));
			case (kind)
				2'd0: begin
					press_button(1'b0, a_lo);
					press_button(1'b1, d);
				end
				2'd1: begin
					a_hi = take_bits(1) ? 4'(take_bits(4)) : 4'h0;
					send_frame({a_hi, a_lo}, d, FRAME_OP_WRITE, 1'b1);
				end
				default: press_button(1'b0, a_lo);
			endcase
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: node_top.f
source/node_pkg.sv
source/node_arbiter.sv
source/bram_slave.sv
source/panel_master.sv
source/uart_rx.sv
source/frame_master.sv
source/seg7_decode.sv
source/node_top.sv
dv/node_tb.sv
